//--- src/ppu_pkg.sv
package ppu_pkg;

	typedef logic [12:0] vram_addr_t; // vram byte address
	typedef logic [7:0]  vram_data_t;
	typedef logic [7:0]  coord_t;     // line number or pixel position
	typedef logic [1:0]  color_t;     // colour index before palette

	typedef struct packed {
		logic bg_enable;
		logic bg_map_sel;    // 1 selects the high map
		logic tile_data_sel; // 1 selects unsigned numbering from 0
		logic win_enable;
		logic win_map_sel;
	} lcdc_t;

	typedef struct packed {
		coord_t scx;
		coord_t scy;
		coord_t wx;
		coord_t wy;
	} scroll_t;

	typedef enum logic [2:0] {
		fetch_idle,
		fetch_map,
		fetch_pat_lo,
		fetch_pat_hi,
		fetch_push // finished tile waits for the buffer
	} fetch_state_t;

	localparam vram_addr_t map_low_base     = 13'h1800;
	localparam vram_addr_t map_high_base    = 13'h1c00;
	localparam vram_addr_t signed_data_base = 13'h1000; // tile 0 of signed numbering
	localparam coord_t     win_x_offset     = 8'd7;

endpackage

//--- src/window_trigger.sv
`timescale 1ns/1ps

module window_trigger #(
	parameter int line_pixels = 160
) (
	input  logic              clk,
	input  logic              reset,
	input  logic              frame_start,
	input  logic              line_start,
	input  logic              line_done,
	input  ppu_pkg::coord_t   line,
	input  ppu_pkg::lcdc_t    lcdc,
	input  ppu_pkg::scroll_t  scroll,
	input  ppu_pkg::coord_t   pixel_x,
	input  logic              tile_advance,
	output logic              win_active,
	output logic              win_restart,
	output ppu_pkg::coord_t   win_col,
	output ppu_pkg::coord_t   win_row
);
	import ppu_pkg::*;

	logic       wy_hit;    // window reached for this frame
	logic       line_on;
	logic       win_armed; // may still start on this line
	logic [8:0] start_x;
	logic [8:0] win_start;

	// wx at or below seven opens the window at the first pixel
	assign start_x = (scroll.wx <= win_x_offset) ? 9'd0 :
		{1'b0, scroll.wx - win_x_offset};

	assign win_restart = line_on && win_armed && wy_hit && ({1'b0, pixel_x} == win_start);

	always_ff @(posedge clk) begin
		if (reset) begin
			wy_hit     <= 1'b0;
			line_on    <= 1'b0;
			win_armed  <= 1'b0;
			win_active <= 1'b0;
			win_col    <= '0;
			win_row    <= '0;
		end else begin
			if (frame_start)
				wy_hit <= 1'b0;
			else if (line_start && !line_on && lcdc.win_enable && line == scroll.wy)
				wy_hit <= 1'b1;

			if (line_done) begin
				line_on <= 1'b0;
				if (win_active)
					win_row <= win_row + 8'd1; // internal window line counter
			end
			if (frame_start)
				win_row <= '0;

			if (line_start && !line_on) begin
				line_on    <= 1'b1;
				win_active <= 1'b0;
				win_armed  <= lcdc.win_enable && (start_x < 9'(line_pixels));
				win_col    <= '0;
			end else if (win_restart) begin
				win_active <= 1'b1;
				win_armed  <= 1'b0; // once per line
				win_col    <= '0;
			end else if (tile_advance && win_active) begin
				win_col <= win_col + 8'd1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (line_start && !line_on)
			win_start <= start_x;
	end

endmodule

//--- src/tile_fetcher.sv
`timescale 1ns/1ps

module tile_fetcher (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 line_start,
	input  ppu_pkg::coord_t      line,
	input  ppu_pkg::lcdc_t       lcdc,
	input  ppu_pkg::scroll_t     scroll,
	input  logic                 win_active,
	input  logic                 win_restart,
	input  ppu_pkg::coord_t      win_col,
	input  ppu_pkg::coord_t      win_row,
	input  logic                 need_tile,
	output ppu_pkg::vram_addr_t  vram_adr,
	output logic                 vram_cyc,
	output logic                 vram_stb,
	input  logic                 vram_ack,
	input  ppu_pkg::vram_data_t  vram_dat_r,
	output ppu_pkg::vram_data_t  tile_lo,
	output ppu_pkg::vram_data_t  tile_hi,
	output logic                 tile_ready,
	input  logic                 tile_taken,
	output logic                 tile_advance
);
	import ppu_pkg::*;

	fetch_state_t state;
	logic         bus_active;
	logic         pending;  // restart waits for the bus cycle in flight
	logic         restart;
	logic         hi_done;
	logic         tile_push;
	logic [4:0]   bg_count; // background tiles pushed this line
	logic [4:0]   bg_col;
	logic [4:0]   map_row;
	logic [4:0]   map_col;
	logic [2:0]   fine_row;
	coord_t       bg_row;
	coord_t       cfg_line;
	coord_t       cfg_scx;
	coord_t       cfg_scy;
	lcdc_t        cfg_lcdc;
	vram_data_t   tile_num;
	vram_data_t   pat_lo;
	vram_data_t   pat_hi;
	vram_data_t   push_hi;
	vram_addr_t   map_base;
	vram_addr_t   map_addr;
	vram_addr_t   tile_base;
	vram_addr_t   pat_addr;

	assign vram_cyc = bus_active;
	assign vram_stb = bus_active;

	assign bg_row   = cfg_line + cfg_scy;
	assign bg_col   = cfg_scx[7:3] + bg_count; // wraps at 32
	assign map_row  = win_active ? win_row[7:3] : bg_row[7:3];
	assign map_col  = win_active ? win_col[4:0] : bg_col;
	assign fine_row = win_active ? win_row[2:0] : bg_row[2:0];
	assign map_base = (win_active ? cfg_lcdc.win_map_sel : cfg_lcdc.bg_map_sel) ?
		map_high_base : map_low_base;
	assign map_addr = map_base + {3'b000, map_row, map_col};

	// signed numbering centres tile 0 on signed_data_base
	assign tile_base = cfg_lcdc.tile_data_sel ? {1'b0, tile_num, 4'b0000} :
		signed_data_base + {tile_num[7], tile_num, 4'b0000};
	assign pat_addr  = tile_base + {9'd0, fine_row, 1'b0} +
		{12'd0, state == fetch_pat_hi};

	assign restart   = line_start || win_restart;
	assign hi_done   = state == fetch_pat_hi && bus_active && vram_ack;
	assign tile_push = !restart && !pending && (!tile_ready || tile_taken) &&
		(state == fetch_push || hi_done);
	assign tile_advance = tile_push;
	assign push_hi   = (state == fetch_push) ? pat_hi : vram_dat_r;

	always_ff @(posedge clk) begin
		if (reset) begin
			state      <= fetch_idle;
			bus_active <= 1'b0;
			pending    <= 1'b0;
			tile_ready <= 1'b0;
			bg_count   <= '0;
		end else begin
			if (restart)
				tile_ready <= 1'b0; // held tile is stale
			else if (tile_push)
				tile_ready <= 1'b1;
			else if (tile_taken)
				tile_ready <= 1'b0;

			if (line_start)
				bg_count <= '0;
			else if (tile_push && !win_active)
				bg_count <= bg_count + 5'd1;

			if (restart) begin
				if (bus_active && !vram_ack) begin
					pending <= 1'b1;
				end else begin
					bus_active <= 1'b0;
					pending    <= 1'b0;
					state      <= fetch_idle;
				end
			end else if (bus_active) begin
				if (vram_ack) begin
					bus_active <= 1'b0;
					if (pending) begin
						pending <= 1'b0;
						state   <= fetch_idle;
					end else begin
						case (state)
							fetch_map:    state <= fetch_pat_lo;
							fetch_pat_lo: state <= fetch_pat_hi;
							fetch_pat_hi: begin
								if (tile_push)
									state <= need_tile ? fetch_map : fetch_idle;
								else
									state <= fetch_push;
							end
							default:      state <= fetch_idle;
						endcase
					end
				end
			end else begin
				case (state)
					fetch_idle: if (need_tile) state <= fetch_map;
					fetch_map, fetch_pat_lo, fetch_pat_hi: bus_active <= 1'b1;
					fetch_push: begin
						if (tile_push)
							state <= need_tile ? fetch_map : fetch_idle;
					end
					default:    state <= fetch_idle;
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (line_start) begin
			cfg_line <= line;
			cfg_scx  <= scroll.scx;
			cfg_scy  <= scroll.scy;
			cfg_lcdc <= lcdc;
		end
		if (!bus_active && (state == fetch_map || state == fetch_pat_lo ||
				state == fetch_pat_hi))
			vram_adr <= (state == fetch_map) ? map_addr : pat_addr; // held for the cycle
		if (bus_active && vram_ack) begin
			if (state == fetch_map)
				tile_num <= vram_dat_r;
			if (state == fetch_pat_lo)
				pat_lo <= vram_dat_r;
			if (state == fetch_pat_hi)
				pat_hi <= vram_dat_r;
		end
		if (tile_push) begin
			tile_lo <= cfg_lcdc.bg_enable ? pat_lo : '0; // layer off shows colour 0
			tile_hi <= cfg_lcdc.bg_enable ? push_hi : '0;
		end
	end

endmodule

//--- src/pixel_shifter.sv
`timescale 1ns/1ps

module pixel_shifter #(
	parameter int line_pixels = 160
) (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 line_start,
	input  ppu_pkg::scroll_t     scroll,
	input  logic                 win_restart,
	input  ppu_pkg::vram_data_t  tile_lo,
	input  ppu_pkg::vram_data_t  tile_hi,
	input  logic                 tile_ready,
	output logic                 tile_taken,
	output logic                 need_tile,
	output ppu_pkg::color_t      pix_color,
	output logic                 pix_valid,
	input  logic                 pix_ready,
	output ppu_pkg::coord_t      pixel_x,
	output logic                 line_done,
	output logic                 line_busy
);
	import ppu_pkg::*;

	vram_data_t sh_lo;
	vram_data_t sh_hi;
	logic [3:0] count;   // pixels left in the shift registers
	logic [2:0] discard; // fine-scroll pixels still to drop
	logic       accept;
	logic       pop;
	logic       last_pixel;
	logic [9:0] filled;
	logic [9:0] limit;

	assign pix_color  = {sh_hi[7], sh_lo[7]}; // msb first
	assign pix_valid  = line_busy && count != 4'd0 && discard == 3'd0 && !win_restart;
	assign accept     = pix_valid && pix_ready;
	assign pop        = accept ||
		(line_busy && count != 4'd0 && discard != 3'd0 && !win_restart);
	assign tile_taken = line_busy && tile_ready && !win_restart &&
		(count == 4'd0 || (count == 4'd1 && pop));
	assign last_pixel = accept && pixel_x == coord_t'(line_pixels - 1);

	// stop asking once the queued pixels cover the rest of the line
	assign filled    = 10'(pixel_x) + 10'(count) + (tile_ready ? 10'd8 : 10'd0);
	assign limit     = 10'(line_pixels) + 10'(discard);
	assign need_tile = line_busy && filled < limit;

	always_ff @(posedge clk) begin
		if (reset) begin
			line_busy <= 1'b0;
			line_done <= 1'b0;
			count     <= '0;
			discard   <= '0;
			pixel_x   <= '0;
		end else begin
			line_done <= last_pixel;
			if (line_start && !line_busy) begin
				line_busy <= 1'b1;
				count     <= '0;
				discard   <= scroll.scx[2:0];
				pixel_x   <= '0;
			end else if (win_restart) begin
				count   <= '0; // window pixels replace the rest
				discard <= '0;
			end else begin
				if (tile_taken)
					count <= 4'd8;
				else if (pop)
					count <= count - 4'd1;
				if (pop && discard != 3'd0)
					discard <= discard - 3'd1;
				if (accept)
					pixel_x <= pixel_x + 8'd1;
				if (last_pixel)
					line_busy <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (tile_taken) begin
			sh_lo <= tile_lo;
			sh_hi <= tile_hi;
		end else if (pop) begin
			sh_lo <= {sh_lo[6:0], 1'b0};
			sh_hi <= {sh_hi[6:0], 1'b0};
		end
	end

endmodule

//--- src/line_renderer.sv
`timescale 1ns/1ps

module line_renderer #(
	parameter int line_pixels = 160
) (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 frame_start,
	input  logic                 line_start,
	input  ppu_pkg::coord_t      line,
	input  ppu_pkg::lcdc_t       lcdc,
	input  ppu_pkg::scroll_t     scroll,
	output ppu_pkg::vram_addr_t  vram_adr,
	input  ppu_pkg::vram_data_t  vram_dat_r,
	output logic                 vram_cyc,
	output logic                 vram_stb,
	input  logic                 vram_ack,
	output ppu_pkg::color_t      pix_color,
	output logic                 pix_valid,
	input  logic                 pix_ready,
	output logic                 line_busy
);
	import ppu_pkg::*;

	logic       win_active;
	logic       win_restart;
	coord_t     win_col;
	coord_t     win_row;
	coord_t     pixel_x;
	logic       need_tile;
	logic       line_done;
	vram_data_t tile_lo;
	vram_data_t tile_hi;
	logic       tile_ready;
	logic       tile_taken;
	logic       tile_advance;

	window_trigger #(
		.line_pixels (line_pixels)
	) window_trigger_inst (
		.clk          (clk),
		.reset        (reset),
		.frame_start  (frame_start),
		.line_start   (line_start),
		.line_done    (line_done),
		.line         (line),
		.lcdc         (lcdc),
		.scroll       (scroll),
		.pixel_x      (pixel_x),
		.tile_advance (tile_advance),
		.win_active   (win_active),
		.win_restart  (win_restart),
		.win_col      (win_col),
		.win_row      (win_row)
	);

	tile_fetcher tile_fetcher_inst (
		.clk          (clk),
		.reset        (reset),
		.line_start   (line_start),
		.line         (line),
		.lcdc         (lcdc),
		.scroll       (scroll),
		.win_active   (win_active),
		.win_restart  (win_restart),
		.win_col      (win_col),
		.win_row      (win_row),
		.need_tile    (need_tile),
		.vram_adr     (vram_adr),
		.vram_cyc     (vram_cyc),
		.vram_stb     (vram_stb),
		.vram_ack     (vram_ack),
		.vram_dat_r   (vram_dat_r),
		.tile_lo      (tile_lo),
		.tile_hi      (tile_hi),
		.tile_ready   (tile_ready),
		.tile_taken   (tile_taken),
		.tile_advance (tile_advance)
	);

	pixel_shifter #(
		.line_pixels (line_pixels)
	) pixel_shifter_inst (
		.clk         (clk),
		.reset       (reset),
		.line_start  (line_start),
		.scroll      (scroll),
		.win_restart (win_restart),
		.tile_lo     (tile_lo),
		.tile_hi     (tile_hi),
		.tile_ready  (tile_ready),
		.tile_taken  (tile_taken),
		.need_tile   (need_tile),
		.pix_color   (pix_color),
		.pix_valid   (pix_valid),
		.pix_ready   (pix_ready),
		.pixel_x     (pixel_x),
		.line_done   (line_done),
		.line_busy   (line_busy)
	);

endmodule

//--- test/vram_model.sv
`timescale 1ns/1ps

module vram_model #(
	parameter int seed_init = 0
) (
	input  logic                 clk,
	input  logic                 reset,
	input  ppu_pkg::vram_addr_t  adr,
	input  logic                 cyc,
	input  logic                 stb,
	output logic                 ack,
	output ppu_pkg::vram_data_t  dat_r
);
	import ppu_pkg::*;

	vram_data_t mem [0:8191];
	int         seed;
	int         wait_left; // wait states before the next ack

	initial begin
		seed      = seed_init;
		wait_left = 0;
		for (int i = 0; i < 8192; i++)
			mem[i] = vram_data_t'($random(seed));
	end

	always @(posedge clk) begin
		if (reset) begin
			ack       <= 1'b0;
			dat_r     <= '0;
			wait_left <= 0;
		end else if (ack) begin
			ack       <= 1'b0; // one ack per cycle of the master
			wait_left <= $random(seed) & 3;
		end else if (cyc && stb) begin
			if (wait_left == 0) begin
				ack   <= 1'b1;
				dat_r <= mem[adr];
			end else begin
				wait_left <= wait_left - 1;
			end
		end
	end

endmodule

//--- test/line_renderer_tb.sv
`timescale 1ns/1ps

module line_renderer_tb;
	import ppu_pkg::*;

	localparam int frames          = 8;
	localparam int lines_per_frame = 16;
	localparam int line_pixels     = 160;

	logic       clk;
	logic       reset;
	logic       frame_start;
	logic       line_start;
	coord_t     line;
	lcdc_t      lcdc;
	scroll_t    scroll;
	vram_addr_t vram_adr;
	vram_data_t vram_dat_r;
	logic       vram_cyc;
	logic       vram_stb;
	logic       vram_ack;
	color_t     pix_color;
	logic       pix_valid;
	logic       pix_ready;
	logic       line_busy;

	int      seed;
	int      errors;
	int      checks;
	int      got_n;
	color_t  got [0:255];
	logic    stalled;    // pixel offered and not taken last cycle
	color_t  held_color;
	lcdc_t   cfg;
	scroll_t scr;
	logic    wy_latch_m; // model of the per-frame window Y latch
	logic    win_on_m;
	int      win_cnt_m;
	int      win_row_m;
	int      win_x_m;
	int      line_m;

	line_renderer #(
		.line_pixels (line_pixels)
	) line_renderer_inst (
		.clk         (clk),
		.reset       (reset),
		.frame_start (frame_start),
		.line_start  (line_start),
		.line        (line),
		.lcdc        (lcdc),
		.scroll      (scroll),
		.vram_adr    (vram_adr),
		.vram_dat_r  (vram_dat_r),
		.vram_cyc    (vram_cyc),
		.vram_stb    (vram_stb),
		.vram_ack    (vram_ack),
		.pix_color   (pix_color),
		.pix_valid   (pix_valid),
		.pix_ready   (pix_ready),
		.line_busy   (line_busy)
	);

	vram_model #(
		.seed_init (32'hadcb_9247)
	) vram_inst (
		.clk   (clk),
		.reset (reset),
		.adr   (vram_adr),
		.cyc   (vram_cyc),
		.stb   (vram_stb),
		.ack   (vram_ack),
		.dat_r (vram_dat_r)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk) begin
		pix_ready <= ($random(seed) & 3) != 0; // ready three cycles in four
		if (stalled) begin
			check_value("pix_valid_held", 1, pix_valid);
			check_value("pix_color_held", held_color, pix_color);
		end
		stalled    = !reset && pix_valid && !pix_ready;
		held_color = pix_color;
		if (!reset && pix_valid && pix_ready) begin
			if (got_n < 256)
				got[got_n] = pix_color;
			got_n = got_n + 1;
		end
	end

	task automatic check_value(string name, integer expected, integer actual);
		checks++;
		if (expected !== actual) begin
			errors++;
			$display("Mismatch %s expected %0d actual %0d", name, expected, actual);
		end
	endtask

	// colour from the map and pattern rules over the vram array
	function automatic int ref_pixel(int x);
		int row;
		int col;
		int bit_i;
		int base;
		int num;
		int adr;
		vram_data_t lo;
		vram_data_t hi;
		if (!cfg.bg_enable)
			return 0;
		if (win_on_m && x >= win_x_m) begin
			row   = win_row_m & 255;
			col   = ((x - win_x_m) >> 3) & 31;
			bit_i = (x - win_x_m) & 7;
			base  = cfg.win_map_sel ? 'h1c00 : 'h1800;
		end else begin
			row   = (line_m + scr.scy) & 255;
			col   = ((x + scr.scx) & 255) >> 3;
			bit_i = (x + scr.scx) & 7;
			base  = cfg.bg_map_sel ? 'h1c00 : 'h1800;
		end
		num = vram_inst.mem[base + (row >> 3) * 32 + col];
		if (cfg.tile_data_sel)
			adr = num * 16;
		else
			adr = 'h1000 + ((num > 127) ? num - 256 : num) * 16; // signed tile number
		adr = adr + (row & 7) * 2;
		lo  = vram_inst.mem[adr];
		hi  = vram_inst.mem[adr + 1];
		return {hi[7 - bit_i], lo[7 - bit_i]};
	endfunction

	task automatic run_line(int ln);
		int n_at_fall;
		string kind;
		line_m = ln;
		if (cfg.win_enable && ln == scr.wy)
			wy_latch_m = 1'b1;
		win_x_m   = (scr.wx <= 7) ? 0 : scr.wx - 7;
		win_on_m  = cfg.win_enable && wy_latch_m && win_x_m < line_pixels;
		win_row_m = win_cnt_m;
		kind      = win_on_m ? "window" : "background";
		@(negedge clk);
		got_n = 0;
		@(posedge clk);
		line       <= coord_t'(ln);
		lcdc       <= cfg;
		scroll     <= scr;
		line_start <= 1'b1;
		@(posedge clk);
		line_start <= 1'b0;
		@(negedge clk);
		check_value("line_busy_rise", 1, line_busy);
		while (line_busy) begin
			if (got_n >= line_pixels)
				check_value("line_busy_after_last", 0, line_busy);
			@(negedge clk);
		end
		n_at_fall = got_n;
		repeat (3) @(negedge clk); // window trigger closes its line
		check_value("pixels_at_busy_fall", line_pixels, n_at_fall);
		check_value("pixels_per_line", line_pixels, got_n);
		for (int x = 0; x < line_pixels && x < got_n; x++)
			check_value($sformatf("%s line %0d x %0d", kind, ln, x), ref_pixel(x), got[x]);
		if (win_on_m)
			win_cnt_m++;
	endtask

	initial begin
		#(frames * lines_per_frame * 4000);
		$display("watchdog timeout, a line did not finish in time");
		$display("SIMULATION FAILED");
		$finish;
	end

	initial begin
		seed        = 32'hadcb_9247;
		errors      = 0;
		checks      = 0;
		got_n       = 0;
		stalled     = 1'b0;
		held_color  = '0;
		reset       = 1'b1;
		frame_start = 1'b0;
		line_start  = 1'b0;
		line        = '0;
		lcdc        = '0;
		scroll      = '0;
		pix_ready   = 1'b0;
		repeat (3) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		check_value("reset_cyc", 0, vram_cyc);
		check_value("reset_stb", 0, vram_stb);
		check_value("reset_pix_valid", 0, pix_valid);
		check_value("reset_line_busy", 0, line_busy);

		for (int f = 0; f < frames; f++) begin
			scr.scy    = coord_t'($random(seed));
			scr.wy     = coord_t'($random(seed) & 15);
			wy_latch_m = 1'b0;
			win_cnt_m  = 0;
			@(posedge clk);
			frame_start <= 1'b1;
			@(posedge clk);
			frame_start <= 1'b0;
			for (int l = 0; l < lines_per_frame; l++) begin
				cfg.bg_enable     = ($random(seed) & 15) != 0;
				cfg.bg_map_sel    = 1'($random(seed));
				cfg.tile_data_sel = 1'($random(seed));
				cfg.win_enable    = ($random(seed) & 3) != 0;
				cfg.win_map_sel   = 1'($random(seed));
				scr.scx           = coord_t'($random(seed));
				case ($random(seed) & 7)
					0: scr.wx = coord_t'($random(seed) & 7); // window from pixel 0
					1: scr.wx = coord_t'(166 + ($random(seed) & 1)); // last pixel or past it
					default: scr.wx = coord_t'(($random(seed) & 127) + ($random(seed) & 31));
				endcase
				run_line(l);
			end
		end

		$display("checks %0d errors %0d", checks, errors);
		if (errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

//--- list.f
src/ppu_pkg.sv
src/window_trigger.sv
src/tile_fetcher.sv
src/pixel_shifter.sv
src/line_renderer.sv
test/vram_model.sv
test/line_renderer_tb.sv

//--- run.sh
#!/bin/sh
# build and run the line renderer testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f list.f \
	--top-module line_renderer_tb --Mdir obj_dir -o sim_line_renderer
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/sim_line_renderer > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "SIMULATION PASSED" sim.log; then
	exit 0
fi
exit 1
